/* tb.f */
+incdir+verification
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/branch_predictor.sv
rtl/reg_file.sv
rtl/id_stage.sv
verification/id_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module id_stage_tb -o id_stage_sim
./obj_dir/id_stage_sim > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi

/* verification/id_ref_model.svh */
logic [XLEN-1:0] model_regs [32];
logic [CTR_BITS-1:0] model_ctrs [8];
localparam logic [31:0] ALU_BASE = {4'd9, 4'd8, 4'd6, 4'd5, 4'd4, 4'd3, 4'd2, 4'd0};

function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
	return alu_op_e'(ALU_BASE[f3*4 +: 4] + 4'(alt && (f3 == 3'd0 || f3 == 3'd5)));
endfunction

function automatic logic [XLEN-1:0] ref_read(input logic [4:0] addr, input wb_t w);
	if (addr == 5'd0)
		return '0;
	return (w.wena && w.addr == addr) ? w.data : model_regs[addr]; // Write-first
endfunction

// Expected bundle for an instruction accepted in this cycle
function automatic id_ex_t ref_bundle(input fetch_t f, input logic m_on, input wb_t w);
	id_ex_t b;
	logic [31:0] ir;
	logic [2:0] f3;
	logic [6:0] f7;
	logic ill;
	logic ecall;
	ir = f.ir;
	f3 = ir[14:12];
	f7 = ir[31:25];
	b = '0;
	ill = 1'b0;
	ecall = 1'b0;
	b.pc = f.pc;
	b.ir = ir;
	b.ctrl.rd_addr = ir[11:7];
	b.ctrl.csr_addr = ir[31:20];
	case (ir[6:0])
		OPC_LUI, OPC_AUIPC: begin
			b.ctrl.rd_wena = 1'b1;
			b.ctrl.sel_im = 1'b1;
			b.ctrl.sel_pc = ir[6:0] == OPC_AUIPC;
			b.imm = {ir[31:12], 12'h000};
		end
		OPC_JAL: begin
			{b.ctrl.rd_wena, b.ctrl.sel_pc, b.ctrl.sel_im} = 3'b111;
			{b.ctrl.jump_ena, b.ctrl.jump_alw} = 2'b11;
			b.ctrl.wb_src = SEL_PC4;
			b.imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
		end
		OPC_JALR: begin
			{b.ctrl.rs1_rena, b.ctrl.rd_wena, b.ctrl.sel_im} = 3'b111;
			{b.ctrl.jump_ena, b.ctrl.jump_alw, b.ctrl.jump_ind} = 3'b111;
			b.ctrl.wb_src = SEL_PC4;
			b.imm = {{20{ir[31]}}, ir[31:20]};
			ill = f3 != 3'd0;
		end
		OPC_BRANCH: begin
			{b.ctrl.rs1_rena, b.ctrl.rs2_rena, b.ctrl.jump_ena} = 3'b111;
			b.imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			b.ctrl.alu_op = alu_op_e'(f3[2] ? 4'(f3) + 4'd8 : 4'(f3) + 4'd10);
			ill = f3 == 3'd2 || f3 == 3'd3;
		end
		OPC_LOAD: begin
			{b.ctrl.rs1_rena, b.ctrl.rd_wena, b.ctrl.sel_im} = 3'b111;
			b.ctrl.wb_src = SEL_MEM;
			b.ctrl.mem_op = mem_op_e'(f3 + 3'd1);
			b.imm = {{20{ir[31]}}, ir[31:20]};
			ill = f3 == 3'd3 || f3 > 3'd5;
		end
		OPC_STORE: begin
			{b.ctrl.rs1_rena, b.ctrl.rs2_rena, b.ctrl.sel_im} = 3'b111;
			b.ctrl.mem_op = mem_op_e'(f3 + 3'd1);
			b.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			ill = f3 > 3'd2;
		end
		OPC_OP_IMM: begin
			{b.ctrl.rs1_rena, b.ctrl.rd_wena, b.ctrl.sel_im} = 3'b111;
			b.ctrl.alu_op = ref_alu(f3, f3 == 3'd5 && ir[30]);
			b.imm = {{20{ir[31]}}, ir[31:20]};
			ill = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
		end
		OPC_OP: begin
			{b.ctrl.rs1_rena, b.ctrl.rs2_rena, b.ctrl.rd_wena} = 3'b111;
			b.ctrl.alu_op = ref_alu(f3, ir[30]);
			if (f7 == 7'h01) begin
				ill = !m_on;
				b.ctrl.wb_src = f3[2] ? SEL_DIV : SEL_MUL;
				b.ctrl.mul_op = mul_op_e'(f3[1:0]);
				b.ctrl.div_op = div_op_e'(f3[1:0]);
			end else
				ill = f7 == 7'h20 ? (f3 != 3'd0 && f3 != 3'd5) : f7 != 7'h00;
		end
		OPC_MISC_MEM: ill = f3 != 3'd0;
		OPC_SYSTEM: begin
			if (ir == INST_ECALL)
				ecall = 1'b1;
			else if (ir == INST_MRET)
				b.trap_ret = 1'b1;
			else if (f3 == 3'd0 || f3 == 3'd4)
				ill = 1'b1;
			else begin
				{b.ctrl.rs1_rena, b.ctrl.rd_wena, b.ctrl.sel_im} = {!f3[2], 1'b1, f3[2]};
				b.ctrl.wb_src = SEL_CSR;
				b.ctrl.csr_op = csr_op_e'(f3[1:0]);
				b.ctrl.csr_rena = !(f3[1:0] == 2'b01 && ir[11:7] == 5'd0); // csrrw to x0
				b.ctrl.csr_wena = !(f3[1] && ir[19:15] == 5'd0); // set/clear with zero mask
				b.imm = {27'b0, ir[19:15]};
			end
		end
		default: ill = 1'b1;
	endcase
	b.ctrl.rs1_addr = b.ctrl.rs1_rena ? ir[19:15] : 5'd0;
	b.ctrl.rs2_addr = b.ctrl.rs2_rena ? ir[24:20] : 5'd0;
	b.rs1_data = ref_read(b.ctrl.rs1_addr, w);
	b.rs2_data = ref_read(b.ctrl.rs2_addr, w);
	b.jump_pred = b.ctrl.jump_ena && !b.ctrl.jump_ind &&
		(b.ctrl.jump_alw || model_ctrs[f.pc[4:2]][1]);
	b.exc_pend = f.exc_pend || ill || ecall;
	b.exc_cause = f.exc_pend ? f.exc_cause : ill ? CAUSE_ILLEGAL_INST :
		ecall ? CAUSE_ECALL_M : '0;
	if (b.exc_pend) begin
		b.ctrl.rd_wena = 1'b0;
		b.ctrl.csr_wena = 1'b0;
	end
	return b;
endfunction

function automatic void model_update(input wb_t w, input ex_fb_t fb);
	if (w.wena && w.addr != 5'd0)
		model_regs[w.addr] = w.data;
	if (fb.jump_ena && !fb.jump_alw) begin
		if (fb.jump_taken && model_ctrs[fb.pc[4:2]] != 2'd3)
			model_ctrs[fb.pc[4:2]]++;
		else if (!fb.jump_taken && model_ctrs[fb.pc[4:2]] != 2'd0)
			model_ctrs[fb.pc[4:2]]--;
	end
endfunction

/* verification/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import decode_pkg::*; ();

	localparam int RUN_LIMIT = 2 * (31 + 130 + 20 + 30 + 150 * 4 + 20 + 40 * 4 + 60);

	logic clk, reset, flush, m_ena, valid_in, ready_out, ready_in;
	logic jump_pred, valid_out, valid_mul, valid_div, ready_mul, ready_div;
	logic [XLEN-1:0] jump_addr;
	fetch_t fetch;
	id_ex_t id_ex;
	ex_fb_t ex_fb;
	wb_t wb;

	logic [31:0] lfsr = 32'hd9a;
	logic [31:0] next_pc = 32'h1000;
	logic bp_on = 1'b0;
	logic mv = 1'b0; // Model of the output register and channel valids
	logic mm = 1'b0;
	logic md = 1'b0;
	id_ex_t held;
	id_ex_t exp_q [$];
	int checks = 0;
	int errors = 0;
	int unit_xfers = 0;
	int cycles = 0;

	`include "id_ref_model.svh"

	id_stage dut (.*);

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Legal ALU, load, store, upper-immediate and optionally CSR encodings
	function automatic logic [31:0] random_inst(input logic with_csr);
		logic [2:0] kind, f3;
		logic [4:0] rd, rs1, rs2;
		logic [11:0] imm;
		logic [19:0] upper;
		kind = rand_bits(3);
		f3 = rand_bits(3);
		rd = rand_bits(5);
		rs1 = rand_bits(5);
		rs2 = rand_bits(5);
		imm = rand_bits(12);
		upper = rand_bits(20);
		case (kind)
			3'd0, 3'd1: begin
				imm[11:5] = (f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) ? 7'h20 : 7'h00;
				return {imm[11:5], rs2, rs1, f3, rd, OPC_OP};
			end
			3'd2, 3'd3: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					imm[11:5] = f3 == 3'd5 && rand_bits(1) ? 7'h20 : 7'h00;
				return {imm, rs1, f3, rd, OPC_OP_IMM};
			end
			3'd4: return {imm, rs1, (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3, rd, OPC_LOAD};
			3'd5: return {imm[11:5], rs2, rs1, f3 > 3'd2 ? 3'd0 : f3, imm[4:0], OPC_STORE};
			3'd6: return {upper, rd, rand_bits(1) ? OPC_LUI : OPC_AUIPC};
			default: begin
				if (!with_csr)
					return {upper, rd, OPC_LUI};
				return {imm, rs1, (f3 == 3'd0 || f3 == 3'd4) ? 3'd1 : f3, rd, OPC_SYSTEM};
			end
		endcase
	endfunction

	// Starts on a falling edge and returns on the one after the transfer
	task automatic issue(input logic [31:0] ir, input logic exc, input logic [31:0] cause);
		logic taken;
		fetch = {next_pc, ir, exc, cause};
		valid_in = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			#1;
			taken = ready_out && !flush;
			@(negedge clk);
		end
		valid_in = 1'b0;
		next_pc += 4;
	endtask

	task automatic end_test(input string name, input int err0);
		bp_on = 1'b0;
		{ready_in, ready_mul, ready_div} = 3'b111;
		while (mv || mm || md)
			@(negedge clk);
		$display("%s finished, %0d errors", name, errors - err0);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycles < RUN_LIMIT)
			@(posedge clk) cycles++;
		$display("Timeout: the tests did not finish within %0d cycles", RUN_LIMIT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	always @(negedge clk)
		if (bp_on)
			{ready_in, ready_mul, ready_div} = rand_bits(3);

	// Compare process sampling 1 ns after each falling edge
	initial begin
		id_ex_t b;
		logic acc, held_csr;
		@(negedge reset);
		forever begin
			#1;
			held_csr = mv && (held.ctrl.csr_rena || held.ctrl.csr_wena);
			check_val("valid_out", valid_out, mv && !flush);
			check_val("ready_out", ready_out, ready_in && !held_csr);
			check_val("valid_mul", valid_mul, mm && !flush);
			check_val("valid_div", valid_div, md && !flush);
			if (valid_out && ready_in) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Error at %0t ns: a bundle left decode with none expected", $time);
				end else begin
					b = exp_q.pop_front();
					check_val("id_ex.pc", id_ex.pc, b.pc);
					check_val("id_ex.ir", id_ex.ir, b.ir);
					check_val("id_ex.imm", id_ex.imm, b.imm);
					check_val("id_ex.ctrl", id_ex.ctrl, b.ctrl);
					check_val("id_ex.rs1_data", id_ex.rs1_data, b.rs1_data);
					check_val("id_ex.rs2_data", id_ex.rs2_data, b.rs2_data);
					check_val("id_ex.jump_pred", id_ex.jump_pred, b.jump_pred);
					check_val("id_ex.trap_ret", id_ex.trap_ret, b.trap_ret);
					check_val("id_ex.exc_pend", id_ex.exc_pend, b.exc_pend);
					check_val("id_ex.exc_cause", id_ex.exc_cause, b.exc_cause);
				end
			end
			if ((valid_mul && ready_mul) || (valid_div && ready_div)) begin
				unit_xfers++;
				check_val("unit channel ir", id_ex.ir, held.ir);
			end
			acc = valid_in && ready_out && !flush;
			if (acc) begin
				b = ref_bundle(fetch, m_ena, wb);
				check_val("jump_pred", jump_pred, b.jump_pred);
				if (b.jump_pred)
					check_val("jump_addr", jump_addr, fetch.pc + b.imm);
			end
			if (flush) begin
				{mv, mm, md} = 3'b000;
				exp_q.delete();
			end else if (acc) begin
				mv = 1'b1;
				held = b;
				exp_q.push_back(b);
				mm = b.ctrl.wb_src == SEL_MUL && !b.exc_pend;
				md = b.ctrl.wb_src == SEL_DIV && !b.exc_pend;
			end else if (mv && ready_in)
				{mv, mm, md} = 3'b000;
			else begin
				if (ready_mul)
					mm = 1'b0;
				if (ready_div)
					md = 1'b0;
			end
			model_update(wb, ex_fb);
			@(negedge clk);
		end
	end

	initial begin
		int err0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < 8; i++)
			model_ctrs[i] = 2'd1;
		{reset, flush, valid_in, m_ena} = 4'b1001;
		{ready_in, ready_mul, ready_div} = 3'b111;
		fetch = '0;
		ex_fb = '0;
		wb = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err0 = errors;
		for (int i = 1; i < 32; i++) begin // Preload through writeback
			wb = {1'b1, 5'(i), rand_bits(32)};
			@(negedge clk);
		end
		wb = '0;
		for (int i = 0; i < 120; i++)
			issue(random_inst(1'b0), 1'b0, '0);
		wb = {1'b1, 5'd6, 32'h0bad_f00d}; // Same-cycle write to rs1
		issue(32'h007302b3, 1'b0, '0);
		wb = {1'b1, 5'd0, 32'h1234_5678}; // Write to x0 is dropped
		issue(32'h00500413, 1'b0, '0);
		wb = '0;
		issue(32'h007302b3, 1'b0, '0);
		end_test("Test 1 random decode and register read", err0);

		err0 = errors;
		issue(32'hffffffff, 1'b0, '0);
		m_ena = 1'b0;
		issue(32'h022081b3, 1'b0, '0);
		m_ena = 1'b1;
		issue(INST_ECALL, 1'b0, '0);
		issue(INST_ECALL, 1'b1, 32'd1);
		issue(32'h300312f3, 1'b1, 32'd5);
		issue(INST_MRET, 1'b0, '0);
		end_test("Test 2 exceptions", err0);

		err0 = errors;
		issue(32'h010000ef, 1'b0, '0);
		issue(32'h00008067, 1'b0, '0);
		for (int i = 0; i < 3; i++) begin
			next_pc = 32'h100;
			issue(32'h00000463, 1'b0, '0);
			ex_fb = {32'h100, 1'b1, 1'b0, 1'b1};
			@(negedge clk);
			ex_fb = {32'h100, 1'b1, 1'b1, 1'b0}; // jal feedback leaves counters alone
			@(negedge clk);
			ex_fb = '0;
		end
		end_test("Test 3 branch prediction", err0);

		err0 = errors;
		bp_on = 1'b1;
		for (int i = 0; i < 150; i++)
			issue(random_inst(1'b1), 1'b0, '0);
		end_test("Test 4 back-pressure and CSR stall", err0);

		err0 = errors;
		issue(32'h007302b3, 1'b0, '0);
		ready_in = 1'b0;
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		ready_in = 1'b1;
		issue(32'h00500413, 1'b0, '0);
		end_test("Test 5 flush", err0);

		err0 = errors;
		bp_on = 1'b1;
		for (int i = 0; i < 40; i++)
			issue({7'h01, 13'(rand_bits(13)), 5'(i), OPC_OP}, i % 8 == 3, 32'd1);
		end_test("Test 6 mul and div channels", err0);

		$display("Checks %0d, errors %0d, unit transfers %0d", checks, errors, unit_xfers);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps

module id_stage import decode_pkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			flush,
	input	logic			m_ena,
	input	logic			valid_in,
	output	logic			ready_out,
	input	fetch_t			fetch,
	output	logic			jump_pred,
	output	logic [XLEN-1:0]	jump_addr,
	output	logic			valid_out,
	input	logic			ready_in,
	output	id_ex_t			id_ex,
	output	logic			valid_mul,
	output	logic			valid_div,
	input	logic			ready_mul,
	input	logic			ready_div,
	input	ex_fb_t			ex_fb,
	input	wb_t			wb
);

	dec_ctrl_t ctrl;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic env_call;
	logic trap_ret;
	logic illegal_inst;
	logic exc_pend;
	logic [XLEN-1:0] exc_cause;
	logic accept;
	logic stall;
	logic valid_q;
	logic mul_pend;
	logic div_pend;
	id_ex_t next_bundle;

	assign accept = valid_in && ready_out;
	assign stall = valid_q && (id_ex.ctrl.csr_rena || id_ex.ctrl.csr_wena); // CSR held
	assign ready_out = ready_in && !stall;
	assign valid_out = valid_q && !flush;
	assign valid_mul = mul_pend && !flush;
	assign valid_div = div_pend && !flush;

	always_comb begin
		if (fetch.exc_pend) begin
			exc_pend = 1'b1;
			exc_cause = fetch.exc_cause;
		end else if (illegal_inst) begin
			exc_pend = 1'b1;
			exc_cause = CAUSE_ILLEGAL_INST;
		end else if (env_call) begin
			exc_pend = 1'b1;
			exc_cause = CAUSE_ECALL_M;
		end else begin
			exc_pend = 1'b0;
			exc_cause = '0;
		end
	end

	always_comb begin
		next_bundle.pc = fetch.pc;
		next_bundle.ir = fetch.ir;
		next_bundle.imm = imm;
		next_bundle.ctrl = ctrl;
		next_bundle.ctrl.rd_wena = ctrl.rd_wena && !exc_pend;
		next_bundle.ctrl.csr_wena = ctrl.csr_wena && !exc_pend;
		next_bundle.rs1_data = rs1_data;
		next_bundle.rs2_data = rs2_data;
		next_bundle.jump_pred = jump_pred;
		next_bundle.trap_ret = trap_ret;
		next_bundle.exc_pend = exc_pend;
		next_bundle.exc_cause = exc_cause;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
			mul_pend <= 1'b0;
			div_pend <= 1'b0;
			id_ex <= '0;
		end else if (flush) begin // Anything fetched in this cycle is wrong-path too
			valid_q <= 1'b0;
			mul_pend <= 1'b0;
			div_pend <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
			mul_pend <= ctrl.wb_src == SEL_MUL && !exc_pend;
			div_pend <= ctrl.wb_src == SEL_DIV && !exc_pend;
			id_ex <= next_bundle;
		end else if (valid_q && ready_in) begin
			valid_q <= 1'b0;
			mul_pend <= 1'b0;
			div_pend <= 1'b0;
		end else begin
			if (ready_mul)
				mul_pend <= 1'b0;
			if (ready_div)
				div_pend <= 1'b0;
		end
	end

	inst_decoder u_decoder (
		.ir		(fetch.ir),
		.m_ena		(m_ena),
		.ctrl		(ctrl),
		.imm		(imm),
		.env_call	(env_call),
		.trap_ret	(trap_ret),
		.illegal_inst	(illegal_inst)
	);

	branch_predictor u_predictor (
		.clk		(clk),
		.reset		(reset),
		.accept		(accept),
		.pc		(fetch.pc),
		.imm		(imm),
		.jump_ena	(ctrl.jump_ena),
		.jump_alw	(ctrl.jump_alw),
		.jump_ind	(ctrl.jump_ind),
		.jump_pred	(jump_pred),
		.jump_addr	(jump_addr),
		.ex_fb		(ex_fb)
	);

	reg_file u_regs (
		.clk		(clk),
		.reset		(reset),
		.wb		(wb),
		.rs1_addr	(ctrl.rs1_addr),
		.rs2_addr	(ctrl.rs2_addr),
		.rs1_data	(rs1_data),
		.rs2_data	(rs2_data)
	);

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import decode_pkg::*; (
	input	logic				clk,
	input	logic				reset,
	input	wb_t				wb,
	input	logic [REG_ADDR_BITS-1:0]	rs1_addr,
	input	logic [REG_ADDR_BITS-1:0]	rs2_addr,
	output	logic [XLEN-1:0]		rs1_data,
	output	logic [XLEN-1:0]		rs2_data
);

	logic [XLEN-1:0] regs [1:31];

	function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_BITS-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb.wena && wb.addr == addr)
			return wb.data; // Write-first bypass
		else
			return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1_addr);
		rs2_data = read_port(rs2_addr);
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.wena && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

endmodule

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import decode_pkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			accept,
	input	logic [XLEN-1:0]	pc,
	input	logic [XLEN-1:0]	imm,
	input	logic			jump_ena,
	input	logic			jump_alw,
	input	logic			jump_ind,
	output	logic			jump_pred,
	output	logic [XLEN-1:0]	jump_addr,
	input	ex_fb_t			ex_fb
);

	localparam int BHT_SIZE = 2 ** BHT_INDEX_BITS;

	logic [CTR_BITS-1:0] bht [BHT_SIZE];
	logic [BHT_INDEX_BITS-1:0] rd_index;
	logic [BHT_INDEX_BITS-1:0] wr_index;
	logic [CTR_BITS-1:0] ctr;
	logic cond_fb;

	assign rd_index = pc[BHT_INDEX_BITS+1:2];
	assign wr_index = ex_fb.pc[BHT_INDEX_BITS+1:2];
	assign ctr = bht[wr_index];
	assign cond_fb = ex_fb.jump_ena && !ex_fb.jump_alw;

	// jal always, branches on counter MSB, never jalr
	assign jump_pred = accept && jump_ena && !jump_ind &&
		(jump_alw || bht[rd_index][CTR_BITS-1]);
	assign jump_addr = pc + imm;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < BHT_SIZE; i++)
				bht[i] <= CTR_BITS'(1); // Weakly not taken
		end else if (cond_fb) begin
			if (ex_fb.jump_taken && ctr != '1)
				bht[wr_index] <= ctr + 1'b1;
			else if (!ex_fb.jump_taken && ctr != '0)
				bht[wr_index] <= ctr - 1'b1;
		end
	end

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
	input	logic [XLEN-1:0]	ir,
	input	logic			m_ena,
	output	dec_ctrl_t		ctrl,
	output	logic [XLEN-1:0]	imm,
	output	logic			env_call,
	output	logic			trap_ret,
	output	logic			illegal_inst
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'h000};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	// Shared by OP and OP-IMM, alt is instruction bit 30
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.rs1_addr = ir[19:15];
		ctrl.rs2_addr = ir[24:20];
		ctrl.rd_addr = ir[11:7];
		ctrl.csr_addr = ir[31:20];
		imm = '0;
		env_call = 1'b0;
		trap_ret = 1'b0;
		illegal_inst = 1'b0;

		case (opcode)
			OPC_LUI: begin
				ctrl.rd_wena = 1'b1;
				ctrl.sel_im = 1'b1; // x0 + imm
				imm = imm_u;
			end
			OPC_AUIPC: begin
				ctrl.rd_wena = 1'b1;
				ctrl.sel_pc = 1'b1;
				ctrl.sel_im = 1'b1;
				imm = imm_u;
			end
			OPC_JAL: begin
				ctrl.rd_wena = 1'b1;
				ctrl.sel_pc = 1'b1;
				ctrl.sel_im = 1'b1;
				ctrl.wb_src = SEL_PC4;
				ctrl.jump_ena = 1'b1;
				ctrl.jump_alw = 1'b1;
				imm = imm_j;
			end
			OPC_JALR: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rd_wena = 1'b1;
				ctrl.sel_im = 1'b1;
				ctrl.wb_src = SEL_PC4;
				ctrl.jump_ena = 1'b1;
				ctrl.jump_alw = 1'b1;
				ctrl.jump_ind = 1'b1;
				imm = imm_i;
				illegal_inst = funct3 != 3'b000;
			end
			OPC_BRANCH: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rs2_rena = 1'b1;
				ctrl.jump_ena = 1'b1;
				imm = imm_b;
				case (funct3)
					3'b000: ctrl.alu_op = ALU_BEQ;
					3'b001: ctrl.alu_op = ALU_BNE;
					3'b100: ctrl.alu_op = ALU_BLT;
					3'b101: ctrl.alu_op = ALU_BGE;
					3'b110: ctrl.alu_op = ALU_BLTU;
					3'b111: ctrl.alu_op = ALU_BGEU;
					default: illegal_inst = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rd_wena = 1'b1;
				ctrl.sel_im = 1'b1;
				ctrl.wb_src = SEL_MEM;
				ctrl.mem_op = mem_op_e'(funct3 + 3'd1);
				imm = imm_i;
				illegal_inst = funct3 == 3'b011 || funct3[2:1] == 2'b11;
			end
			OPC_STORE: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rs2_rena = 1'b1;
				ctrl.sel_im = 1'b1;
				ctrl.mem_op = mem_op_e'(funct3 + 3'd1);
				imm = imm_s;
				illegal_inst = funct3[2] || funct3[1:0] == 2'b11;
			end
			OPC_OP_IMM: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rd_wena = 1'b1;
				ctrl.sel_im = 1'b1;
				ctrl.alu_op = alu_sel(funct3, funct3 == 3'b101 && ir[30]);
				imm = imm_i;
				if (funct3 == 3'b001)
					illegal_inst = funct7 != 7'b0000000;
				else if (funct3 == 3'b101)
					illegal_inst = funct7 != 7'b0000000 && funct7 != 7'b0100000;
			end
			OPC_OP: begin
				ctrl.rs1_rena = 1'b1;
				ctrl.rs2_rena = 1'b1;
				ctrl.rd_wena = 1'b1;
				ctrl.alu_op = alu_sel(funct3, ir[30]);
				if (funct7 == 7'b0000001) begin
					illegal_inst = !m_ena;
					ctrl.wb_src = funct3[2] ? SEL_DIV : SEL_MUL;
					ctrl.mul_op = mul_op_e'(funct3[1:0]);
					ctrl.div_op = div_op_e'(funct3[1:0]);
				end else if (funct7 == 7'b0100000)
					illegal_inst = funct3 != 3'b000 && funct3 != 3'b101;
				else
					illegal_inst = funct7 != 7'b0000000;
			end
			OPC_MISC_MEM: illegal_inst = funct3 != 3'b000; // fence is a no-op here
			OPC_SYSTEM: begin
				if (funct3 == 3'b000) begin
					env_call = ir == INST_ECALL;
					trap_ret = ir == INST_MRET;
					illegal_inst = !env_call && !trap_ret;
				end else if (funct3 == 3'b100)
					illegal_inst = 1'b1;
				else begin
					ctrl.rs1_rena = !funct3[2];
					ctrl.rd_wena = 1'b1;
					ctrl.sel_im = funct3[2]; // zimm form
					ctrl.wb_src = SEL_CSR;
					ctrl.csr_op = csr_op_e'(funct3[1:0]);
					ctrl.csr_rena = !(funct3[1:0] == 2'b01 && ir[11:7] == '0);
					ctrl.csr_wena = !(funct3[1] && ir[19:15] == '0);
					imm = {27'b0, ir[19:15]};
				end
			end
			default: illegal_inst = 1'b1;
		endcase

		// Unused source addresses read as x0
		if (!ctrl.rs1_rena)
			ctrl.rs1_addr = '0;
		if (!ctrl.rs2_rena)
			ctrl.rs2_addr = '0;
	end

endmodule

/* rtl/decode_pkg.sv */
package decode_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_BITS = 5;
	localparam int BHT_INDEX_BITS = 3; // 8 entries, PC bits 4:2
	localparam int CTR_BITS = 2;

	localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INST = 32'd2;
	localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [XLEN-1:0] INST_ECALL = 32'h00000073;
	localparam logic [XLEN-1:0] INST_MRET = 32'h30200073;

	typedef enum logic [2:0] {SEL_ALU, SEL_MEM, SEL_CSR, SEL_PC4, SEL_MUL, SEL_DIV} wb_src_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
		ALU_OR, ALU_AND, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	// Access width is funct3 + 1, a store is a mem_op with wb_src other than SEL_MEM
	typedef enum logic [2:0] {
		MEM_NONE = 3'd0, MEM_B = 3'd1, MEM_H = 3'd2, MEM_W = 3'd3, MEM_BU = 3'd5, MEM_HU = 3'd6
	} mem_op_e;

	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;
	typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;
	typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

	typedef struct packed {
		logic rs1_rena;
		logic [REG_ADDR_BITS-1:0] rs1_addr;
		logic rs2_rena;
		logic [REG_ADDR_BITS-1:0] rs2_addr;
		logic rd_wena;
		logic [REG_ADDR_BITS-1:0] rd_addr;
		logic csr_rena;
		logic csr_wena;
		logic [11:0] csr_addr;
		logic sel_pc; // Operand A is the PC
		logic sel_im; // Operand B is the immediate
		wb_src_e wb_src;
		alu_op_e alu_op;
		mem_op_e mem_op;
		csr_op_e csr_op;
		mul_op_e mul_op;
		div_op_e div_op;
		logic jump_ena;
		logic jump_ind;
		logic jump_alw;
	} dec_ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] ir;
		logic exc_pend;
		logic [XLEN-1:0] exc_cause;
	} fetch_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] ir;
		logic [XLEN-1:0] imm;
		dec_ctrl_t ctrl;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic jump_pred;
		logic trap_ret;
		logic exc_pend;
		logic [XLEN-1:0] exc_cause;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic jump_ena;
		logic jump_alw;
		logic jump_taken;
	} ex_fb_t;

	typedef struct packed {
		logic wena;
		logic [REG_ADDR_BITS-1:0] addr;
		logic [XLEN-1:0] data;
	} wb_t;

endpackage
